/* idecode.f */
isa_pkg.sv
flow_pkg.sv
decode_if.sv
opcode_decoder.sv
operand_assembler.sv
flow_ctrl.sv
idecode.sv
tb_clk_gen.sv
idecode_tb.sv

/* Makefile */
# Verilator build and run of the instruction decoder testbench

SRCS = $(shell cat idecode.f)

.PHONY: all run clean

all: run

obj_dir/Videcode_tb: idecode.f $(SRCS)
	verilator --binary --timing --assert --top-module idecode_tb \
		-f idecode.f -Mdir obj_dir -o Videcode_tb

run: obj_dir/Videcode_tb
	@out="$$(./obj_dir/Videcode_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* idecode_tb.sv */
// idecode_tb: directed tests of the instruction decoder
// one task per behavior, results per test and a closing summary
`timescale 1ns/1ns

module idecode_tb
    import isa_pkg::*, flow_pkg::*;
();

    localparam int sel_branch   = 0;
    localparam int sel_call     = 1;
    localparam int sel_ret      = 2;
    localparam int sel_soft_rst = 3;
    localparam int sel_halted   = 4;
    localparam int sel_any      = 5;

    logic       clk;
    logic       reset_;
    logic       decode_en;
    inst_t      inst;
    sr_t        sr;
    logic [3:0] exec_ctrl;
    reg_idx_t   src0_reg;
    reg_idx_t   src1_reg;
    reg_idx_t   dst_reg;
    logic       src0_rd_en;
    logic       src1_rd_en;
    logic       exec_en;
    logic       exec_imm_val_vld;
    inst_t      exec_imm_val;
    addr_t      exec_addr;
    logic       fetch_en;
    logic       call;
    logic       branch;
    logic       ret;
    logic       soft_rst;
    logic       halted;

    int    seed = 66545;
    string cur_test;
    int    test_errs;
    int    tests_passed;
    int    tests_failed;

    tb_clk_gen i_clk_gen (.clk(clk), .reset_(reset_));

    idecode i_dut (.*);

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // ALU base codes 1..5 in ISA order
    function automatic exec_op_t expected_alu_op(input int b);
        case (b)
            1:       return ALU_ADD;
            2:       return ALU_SUB;
            3:       return ALU_AND;
            4:       return ALU_OR;
            default: return ALU_XOR;
        endcase
    endfunction

    function automatic logic pulse_of(input int which);
        case (which)
            sel_branch:   return branch;
            sel_call:     return call;
            sel_ret:      return ret;
            sel_soft_rst: return soft_rst;
            sel_halted:   return halted;
            default:      return branch | call | ret | soft_rst | halted;
        endcase
    endfunction

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            $display("PASS %s", cur_test);
            tests_passed++;
        end else begin
            $display("FAIL %s (%0d errors)", cur_test, test_errs);
            tests_failed++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        test_errs++;
    endtask

    task automatic check_op(input string what, input exec_op_t exp, input exec_op_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %s (%0d), actual %0d",
                     cur_test, what, exp.name(), exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_byte(input string what, input inst_t exp, input inst_t act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic drive_byte(input inst_t b, input logic en);
        @(posedge clk);
        inst      <= b;
        decode_en <= en;
    endtask

    task automatic drive_status(input logic z, input logic nz);
        sr_t v;
        v             = '0;
        v[SR_Z_BIT]   = z;
        v[SR_NZ_BIT]  = nz;
        @(posedge clk);
        sr <= v;
    endtask

    // looks for a pulse within a few cycles, checks it lasts one cycle
    task automatic expect_pulse(input int which, input string what, input logic want);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 4 && !seen; i++) begin
            @(negedge clk);
            seen = pulse_of(which);
        end
        if (want && !seen) begin
            report_failure({"timed out waiting for ", what, " pulse"});
        end else begin
            check_bit({what, " pulse"}, want, seen);
        end
        if (want && seen) begin
            @(negedge clk);
            check_bit({what, " pulse width"}, 1'b0, pulse_of(which));
        end
    endtask

    task automatic issue_misc(input misc_op_t m, input exec_op_t exp_op);
        drive_byte({CTRL, MISC, m}, 1'b1);
        drive_byte(8'h00, 1'b0);
        @(negedge clk);
        check_op({m.name(), " exec_ctrl"}, exp_op, exec_op_t'(exec_ctrl));
        check_bit({m.name(), " exec_en"}, 1'b1, exec_en);
    endtask

    task automatic issue_ctrl(input logic is_call, input addr_t t, input logic want);
        string     what;
        ctrl_sub_t sub;
        what = is_call ? "call" : "branch";
        sub  = is_call ? CALL : JMP;
        drive_byte({CTRL, sub, t[10:8]}, 1'b1);
        drive_byte(t[7:0], 1'b1);
        @(negedge clk);
        check_op({what, " exec_ctrl"}, is_call ? OP_CALL : OP_JMP, exec_op_t'(exec_ctrl));
        drive_byte(8'h00, 1'b0);
        @(negedge clk);
        check_addr({what, " target"}, t, exec_addr);
        check_op({what, " operand exec_ctrl"}, EXEC_NOP, exec_op_t'(exec_ctrl));
        check_bit({what, " operand exec_en"}, 1'b0, exec_en);
        expect_pulse(is_call ? sel_call : sel_branch, what, want);
    endtask

    task automatic test_reset_and_reg();
        logic [31:0] r;
        reg_idx_t    s0;
        reg_idx_t    s1;
        begin_test("reset_and_reg");
        @(negedge clk);
        check_op("reset exec_ctrl", EXEC_NOP, exec_op_t'(exec_ctrl));
        check_bit("reset fetch_en", 1'b1, fetch_en);
        check_bit("reset exec_en", 1'b0, exec_en);
        check_bit("reset src0_rd_en", 1'b0, src0_rd_en);
        check_bit("reset src1_rd_en", 1'b0, src1_rd_en);
        check_bit("reset imm valid", 1'b0, exec_imm_val_vld);
        check_bit("reset pulses", 1'b0, pulse_of(sel_any));
        for (int b = 1; b <= 5; b++) begin
            r  = next_rand();
            s0 = r[3:2];
            s1 = r[1:0];
            drive_byte({b[2:0], 1'b0, s0, s1}, 1'b1);
            drive_byte(8'h00, 1'b0);
            @(negedge clk);
            check_op("alu exec_ctrl", expected_alu_op(b), exec_op_t'(exec_ctrl));
            check_reg("alu src0", s0, src0_reg);
            check_reg("alu src1", s1, src1_reg);
            check_reg("alu dst", s1, dst_reg);
            check_bit("alu src0_rd_en", 1'b1, src0_rd_en);
            check_bit("alu src1_rd_en", 1'b1, src1_rd_en);
            check_bit("alu exec_en", 1'b1, exec_en);
            @(negedge clk);
            check_bit("alu exec_en width", 1'b0, exec_en);
        end
        finish_test();
    endtask

    task automatic test_immediate();
        logic [31:0] r;
        reg_idx_t    s0;
        reg_idx_t    d;
        inst_t       imm;
        begin_test("immediate");
        for (int b = 1; b <= 5; b++) begin
            r   = next_rand();
            s0  = r[3:2];
            d   = r[1:0];
            imm = r[15:8];
            drive_byte({b[2:0], 1'b1, s0, d}, 1'b1);
            drive_byte(imm, 1'b1);
            @(negedge clk);
            check_op("imm exec_ctrl", expected_alu_op(b), exec_op_t'(exec_ctrl));
            check_reg("imm src0", s0, src0_reg);
            check_reg("imm dst", d, dst_reg);
            check_bit("imm src0_rd_en", 1'b1, src0_rd_en);
            check_bit("imm src1_rd_en", 1'b0, src1_rd_en);
            check_bit("imm exec_en", 1'b1, exec_en);
            drive_byte(8'h00, 1'b0);
            @(negedge clk);
            check_byte("imm value", imm, exec_imm_val);
            check_bit("imm valid", 1'b1, exec_imm_val_vld);
            check_op("operand exec_ctrl", EXEC_NOP, exec_op_t'(exec_ctrl));
            issue_misc(NOP, EXEC_NOP);
            check_bit("imm valid cleared", 1'b0, exec_imm_val_vld);
        end
        finish_test();
    endtask

    task automatic test_load_store();
        logic [31:0] r;
        reg_idx_t    rg;
        addr_t       a;
        base_op_t    base;
        begin_test("load_store");
        for (int i = 0; i < 4; i++) begin
            r    = next_rand();
            rg   = r[1:0];
            a    = r[18:8];
            base = i[0] ? ST : LD;
            drive_byte({base, rg, a[10:8]}, 1'b1);
            drive_byte(a[7:0], 1'b1);
            @(negedge clk);
            if (i[0]) begin
                check_op("st exec_ctrl", MEM_WR, exec_op_t'(exec_ctrl));
                check_reg("st src0", rg, src0_reg);
                check_bit("st src0_rd_en", 1'b1, src0_rd_en);
            end else begin
                check_op("ld exec_ctrl", MEM_RD, exec_op_t'(exec_ctrl));
                check_reg("ld dst", rg, dst_reg);
                check_bit("ld src0_rd_en", 1'b0, src0_rd_en);
            end
            check_bit("mem exec_en", 1'b1, exec_en);
            drive_byte(8'h00, 1'b0);
            @(negedge clk);
            check_addr("mem address", a, exec_addr);
        end
        finish_test();
    endtask

    task automatic test_cond_branch();
        logic [31:0] r;
        misc_op_t    mode;
        logic        bcz;
        logic        bcnz;
        logic        take;
        begin_test("cond_branch");
        for (int m = 0; m < 3; m++) begin
            mode = (m == 0) ? CLR_BC : ((m == 1) ? SET_BCZ : SET_BCNZ);
            issue_misc(mode, EXEC_IDLE);
            bcz  = (mode == SET_BCZ);
            bcnz = (mode == SET_BCNZ);
            for (int s = 0; s < 4; s++) begin
                drive_status(s[1], s[0]);                 // z, nz
                take = (!bcz && !bcnz) || (bcnz && s[0]) || (bcz && s[1]);
                r    = next_rand();
                issue_ctrl(1'b0, r[10:0], take);
                issue_ctrl(1'b1, r[26:16], take);
            end
        end
        issue_misc(CLR_BC, EXEC_IDLE);
        drive_status(1'b0, 1'b0);
        finish_test();
    endtask

    task automatic test_flow_ops();
        logic [31:0] r;
        begin_test("flow_ops");
        r = next_rand();
        issue_misc(HALT, EXEC_NOP);
        expect_pulse(sel_halted, "halted", 1'b1);
        check_bit("fetch_en after halt", 1'b0, fetch_en);
        issue_ctrl(1'b0, r[10:0], 1'b1);
        check_bit("fetch_en after jmp", 1'b1, fetch_en);
        issue_misc(RET, OP_RET);
        expect_pulse(sel_ret, "ret", 1'b1);
        check_bit("fetch_en after ret", 1'b0, fetch_en);
        issue_ctrl(1'b0, r[26:16], 1'b1);
        check_bit("fetch_en after second jmp", 1'b1, fetch_en);
        issue_misc(RST, EXEC_NOP);
        expect_pulse(sel_soft_rst, "soft_rst", 1'b1);
        issue_misc(NOP, EXEC_NOP);
        expect_pulse(sel_any, "control", 1'b0);
        finish_test();
    endtask

    task automatic test_decode_idle();
        logic [31:0] r;
        reg_idx_t    s0;
        reg_idx_t    d;
        inst_t       imm;
        begin_test("decode_en_low");
        r   = next_rand();
        s0  = r[3:2];
        d   = r[1:0];
        imm = r[15:8];
        drive_byte({SUB, 1'b1, s0, d}, 1'b1);
        drive_byte(imm, 1'b0);
        @(negedge clk);
        check_op("first byte exec_ctrl", ALU_SUB, exec_op_t'(exec_ctrl));
        check_bit("first byte exec_en", 1'b1, exec_en);
        for (int i = 0; i < 3; i++) begin
            drive_byte(~imm, 1'b0);                       // junk while idle
            @(negedge clk);
            check_bit("idle exec_en", 1'b0, exec_en);
            check_bit("idle src0_rd_en", 1'b0, src0_rd_en);
            check_op("idle exec_ctrl", ALU_SUB, exec_op_t'(exec_ctrl));
            check_reg("idle src0", s0, src0_reg);
            check_reg("idle dst", d, dst_reg);
            check_bit("idle imm valid", 1'b0, exec_imm_val_vld);
        end
        drive_byte(imm, 1'b1);
        drive_byte(8'h00, 1'b0);
        @(negedge clk);
        check_byte("late imm value", imm, exec_imm_val);
        check_bit("late imm valid", 1'b1, exec_imm_val_vld);
        check_op("late operand exec_ctrl", EXEC_NOP, exec_op_t'(exec_ctrl));
        drive_byte({XOR, 1'b0, s0, d}, 1'b1);
        drive_byte(8'h00, 1'b0);
        @(negedge clk);
        check_op("next first byte", ALU_XOR, exec_op_t'(exec_ctrl));
        check_bit("next exec_en", 1'b1, exec_en);
        finish_test();
    endtask

    initial begin
        decode_en    = 1'b0;
        inst         = '0;
        sr           = '0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = "reset";
        for (int i = 0; i < 40 && reset_ !== 1'b1; i++)
            @(posedge clk);
        if (reset_ !== 1'b1) begin
            $display("reset was never released");
            tests_failed++;
        end
        test_reset_and_reg();
        test_immediate();
        test_load_store();
        test_cond_branch();
        test_flow_ops();
        test_decode_idle();
        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
// tb_clk_gen: testbench clock and reset
// 4 ns clock, reset_ held low for the first 10 cycles
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic reset_
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        reset_ = 1'b0;
        repeat (10) @(posedge clk);
        reset_ <= 1'b1;    // released on an edge like any other input
    end

endmodule

/* idecode.sv */
// idecode: instruction decoder of the 8-bit CPU
// joins opcode decoder, operand assembler and flow controller
`timescale 1ns/1ns

module idecode (
    input  logic        clk,
    input  logic        reset_,
    input  logic        decode_en,
    input  logic [7:0]  inst,
    input  logic [7:0]  sr,          // status register
    output logic [3:0]  exec_ctrl,
    output logic [1:0]  src0_reg,
    output logic [1:0]  src1_reg,
    output logic [1:0]  dst_reg,
    output logic        src0_rd_en,
    output logic        src1_rd_en,
    output logic        exec_en,
    output logic        exec_imm_val_vld,
    output logic [7:0]  exec_imm_val,
    output logic [10:0] exec_addr,
    output logic        fetch_en,
    output logic        call,
    output logic        branch,
    output logic        ret,
    output logic        soft_rst,
    output logic        halted
);

    decode_if dif ();

    opcode_decoder i_opcode_decoder (
        .clk        (clk),
        .reset_     (reset_),
        .decode_en  (decode_en),
        .inst       (inst),
        .dif        (dif.decoder),
        .exec_ctrl  (exec_ctrl),
        .src0_reg   (src0_reg),
        .src1_reg   (src1_reg),
        .dst_reg    (dst_reg),
        .src0_rd_en (src0_rd_en),
        .src1_rd_en (src1_rd_en),
        .exec_en    (exec_en)
    );

    operand_assembler i_operand_assembler (
        .clk              (clk),
        .reset_           (reset_),
        .decode_en        (decode_en),
        .inst             (inst),
        .dif              (dif.assembler),
        .exec_imm_val     (exec_imm_val),
        .exec_imm_val_vld (exec_imm_val_vld),
        .exec_addr        (exec_addr)
    );

    flow_ctrl i_flow_ctrl (
        .clk      (clk),
        .reset_   (reset_),
        .sr       (sr),
        .dif      (dif.flow),
        .fetch_en (fetch_en),
        .call     (call),
        .branch   (branch),
        .ret      (ret),
        .soft_rst (soft_rst),
        .halted   (halted)
    );

endmodule

/* flow_ctrl.sv */
// flow_ctrl: control register and program flow pulses
// evaluates branch condition against status, drives fetch enable
`timescale 1ns/1ns

module flow_ctrl
    import flow_pkg::*;
(
    input  logic clk,
    input  logic reset_,
    input  sr_t  sr,
    decode_if.flow dif,
    output logic fetch_en,
    output logic call,
    output logic branch,
    output logic ret,
    output logic soft_rst,
    output logic halted
);

    cr_t  cr;
    logic take;    // branch condition met

    // unconditional when no condition bit is set
    assign take = !(cr[CR_BCZ_BIT] || cr[CR_BCNZ_BIT])
               || (cr[CR_BCNZ_BIT] && sr[SR_NZ_BIT])
               || (cr[CR_BCZ_BIT] && sr[SR_Z_BIT]);

    always_ff @(posedge clk) begin
        if (!reset_) begin
            cr       <= '0;
            fetch_en <= 1'b1;
            call     <= 1'b0;
            branch   <= 1'b0;
            ret      <= 1'b0;
            soft_rst <= 1'b0;
            halted   <= 1'b0;
        end else begin
            branch   <= dif.jump_req && take;
            call     <= dif.call_req && take;
            ret      <= dif.flow_op == FLOW_RET;
            halted   <= dif.flow_op == FLOW_HALT;
            soft_rst <= dif.flow_op == FLOW_RST;

            if (dif.jump_req || dif.call_req)
                fetch_en <= 1'b1;               // resume fetch at target
            else if (dif.flow_op == FLOW_RET || dif.flow_op == FLOW_HALT)
                fetch_en <= 1'b0;

            case (dif.flow_op)
                FLOW_SET_BCZ: begin
                    cr[CR_BCZ_BIT]  <= 1'b1;
                    cr[CR_BCNZ_BIT] <= 1'b0;
                end
                FLOW_SET_BCNZ: begin
                    cr[CR_BCZ_BIT]  <= 1'b0;
                    cr[CR_BCNZ_BIT] <= 1'b1;
                end
                FLOW_CLR_BC: begin
                    cr[CR_BCZ_BIT]  <= 1'b0;
                    cr[CR_BCNZ_BIT] <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    a_cr_excl: assert property (@(posedge clk) disable iff (!reset_)
        !(cr[CR_BCZ_BIT] && cr[CR_BCNZ_BIT]))
        else $error("both branch condition bits set");

endmodule

/* operand_assembler.sv */
// operand_assembler: second instruction byte handling
// builds the immediate value or the 11-bit address, requests jumps and calls
`timescale 1ns/1ns

module operand_assembler
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset_,
    input  logic  decode_en,
    input  inst_t inst,
    decode_if.assembler dif,
    output inst_t exec_imm_val,
    output logic  exec_imm_val_vld,
    output addr_t exec_addr
);

    logic first_byte;    // decoder consumed a first byte

    assign first_byte = decode_en && !dif.operand_stb;

    always_ff @(posedge clk) begin
        if (!reset_) begin
            exec_imm_val_vld <= 1'b0;
            dif.jump_req     <= 1'b0;
            dif.call_req     <= 1'b0;
        end else begin
            dif.jump_req <= dif.operand_stb && dif.operand_kind == OPK_JMP;
            dif.call_req <= dif.operand_stb && dif.operand_kind == OPK_CALL;
            if (dif.operand_stb && dif.operand_kind == OPK_IMM)
                exec_imm_val_vld <= 1'b1;
            else if (first_byte)
                exec_imm_val_vld <= 1'b0;       // held until next instruction
        end
    end

    always_ff @(posedge clk) begin
        if (dif.operand_stb) begin
            if (dif.operand_kind == OPK_IMM)
                exec_imm_val <= inst;
            else
                exec_addr <= {dif.addr_hi, inst};   // mem, jmp and call targets
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!reset_)
        !(dif.jump_req && dif.call_req))
        else $error("jump and call requested together");

endmodule

/* opcode_decoder.sv */
// opcode_decoder: classifies first instruction bytes
// registers execute controls and tracks the pending operand byte
`timescale 1ns/1ns

module opcode_decoder
    import isa_pkg::*, flow_pkg::*;
(
    input  logic     clk,
    input  logic     reset_,
    input  logic     decode_en,
    input  inst_t    inst,
    decode_if.decoder dif,
    output exec_op_t exec_ctrl,
    output reg_idx_t src0_reg,
    output reg_idx_t src1_reg,
    output reg_idx_t dst_reg,
    output logic     src0_rd_en,
    output logic     src1_rd_en,
    output logic     exec_en
);

    logic          pending;         // next byte is an operand
    logic          first_stb;
    base_op_t      base;
    ctrl_sub_t     sub;
    misc_op_t      misc;
    logic          imm_flag;

    exec_op_t      nxt_op;
    logic          nxt_rd0;
    logic          nxt_rd1;
    logic          nxt_pend;
    operand_kind_t nxt_kind;
    flow_op_t      nxt_flow;
    logic          ld_src0;
    logic          ld_src1;
    logic          ld_dst;
    reg_idx_t      src0_sel;
    reg_idx_t      dst_sel;

    assign first_stb       = decode_en && !pending;
    assign dif.operand_stb = decode_en && pending;

    assign base     = base_op_t'(inst[7:5]);
    assign sub      = ctrl_sub_t'(inst[4:3]);
    assign misc     = misc_op_t'(inst[2:0]);
    assign imm_flag = inst[4];

    always_comb begin
        nxt_op   = EXEC_NOP;
        nxt_rd0  = 1'b0;
        nxt_rd1  = 1'b0;
        nxt_pend = 1'b0;
        nxt_kind = OPK_IMM;
        nxt_flow = FLOW_NONE;
        ld_src0  = 1'b0;
        ld_src1  = 1'b0;
        ld_dst   = 1'b0;
        src0_sel = inst[3:2];
        dst_sel  = inst[1:0];
        case (base)
            CTRL: begin
                case (sub)
                    MISC: begin
                        case (misc)
                            RET: begin
                                nxt_op   = OP_RET;
                                nxt_flow = FLOW_RET;
                            end
                            HALT:    nxt_flow = FLOW_HALT;
                            RST:     nxt_flow = FLOW_RST;
                            SET_BCZ: begin
                                nxt_op   = EXEC_IDLE;
                                nxt_flow = FLOW_SET_BCZ;
                            end
                            SET_BCNZ: begin
                                nxt_op   = EXEC_IDLE;
                                nxt_flow = FLOW_SET_BCNZ;
                            end
                            CLR_BC: begin
                                nxt_op   = EXEC_IDLE;
                                nxt_flow = FLOW_CLR_BC;
                            end
                            default: ;            // nop
                        endcase
                    end
                    JMP: begin
                        nxt_op   = OP_JMP;
                        nxt_pend = 1'b1;
                        nxt_kind = OPK_JMP;
                    end
                    CALL: begin
                        nxt_op   = OP_CALL;
                        nxt_pend = 1'b1;
                        nxt_kind = OPK_CALL;
                    end
                    default: ;                    // usr group runs as nop
                endcase
            end
            ADD, SUB, AND, OR, XOR: begin
                nxt_op  = alu_exec_op(base);
                ld_src0 = 1'b1;
                ld_dst  = 1'b1;
                nxt_rd0 = 1'b1;
                if (imm_flag) begin
                    nxt_pend = 1'b1;              // src1 comes from the next byte
                end else begin
                    ld_src1 = 1'b1;
                    nxt_rd1 = 1'b1;
                end
            end
            LD: begin
                nxt_op   = MEM_RD;
                ld_dst   = 1'b1;
                dst_sel  = inst[4:3];
                nxt_pend = 1'b1;
                nxt_kind = OPK_MEM;
            end
            default: begin                        // st
                nxt_op   = MEM_WR;
                ld_src0  = 1'b1;
                src0_sel = inst[4:3];
                nxt_rd0  = 1'b1;
                nxt_pend = 1'b1;
                nxt_kind = OPK_MEM;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            pending     <= 1'b0;
            exec_ctrl   <= EXEC_NOP;
            exec_en     <= 1'b0;
            src0_rd_en  <= 1'b0;
            src1_rd_en  <= 1'b0;
            dif.flow_op <= FLOW_NONE;
        end else begin
            exec_en     <= first_stb;
            src0_rd_en  <= first_stb && nxt_rd0;
            src1_rd_en  <= first_stb && nxt_rd1;
            dif.flow_op <= first_stb ? nxt_flow : FLOW_NONE;
            if (decode_en) begin
                pending   <= !pending && nxt_pend;
                exec_ctrl <= pending ? EXEC_NOP : nxt_op;   // operand byte idles execute
            end
        end
    end

    // register fields and operand context only change on a first byte
    always_ff @(posedge clk) begin
        if (first_stb) begin
            if (ld_src0)
                src0_reg <= src0_sel;
            if (ld_src1)
                src1_reg <= inst[1:0];
            if (ld_dst)
                dst_reg <= dst_sel;
            if (nxt_pend) begin
                dif.operand_kind <= nxt_kind;
                dif.addr_hi      <= inst[2:0];
            end
        end
    end

    a_legal_ctrl: assert property (@(posedge clk) disable iff (!reset_)
        first_stb && base == CTRL |-> sub != USR && !(sub == MISC && inst[2:0] == 3'd7))
        else $error("illegal or usr control byte decoded");

    // an operand byte never coincides with a misc request to the flow controller
    a_stb_no_flow: assert property (@(posedge clk) disable iff (!reset_)
        dif.operand_stb |-> dif.flow_op == FLOW_NONE)
        else $error("operand strobe with pending flow request");

endmodule

/* decode_if.sv */
// decode_if: strobes and values shared by the decoder peers
// no handshake, every signal is a one-cycle strobe or qualified by one
`timescale 1ns/1ns

interface decode_if
    import isa_pkg::*, flow_pkg::*;
();

    logic          operand_stb;     // current inst is a second byte
    operand_kind_t operand_kind;
    addr_hi_t      addr_hi;
    flow_op_t      flow_op;         // misc request, one cycle
    logic          jump_req;
    logic          call_req;

    modport decoder (output operand_stb, operand_kind, addr_hi, flow_op);

    modport assembler (
        input  operand_stb, operand_kind, addr_hi,
        output jump_req, call_req
    );

    modport flow (input flow_op, jump_req, call_req);

endinterface

/* flow_pkg.sv */
// flow_pkg: program flow definitions
// control/status register bit positions and decoder to flow controller requests
package flow_pkg;

    typedef logic [7:0] sr_t;    // status register
    typedef logic [7:0] cr_t;    // control register

    // control register
    localparam int CR_BCZ_BIT  = 0;    // branch if Z
    localparam int CR_BCNZ_BIT = 1;    // branch if NZ

    // status register
    localparam int SR_NZ_BIT = 2;
    localparam int SR_Z_BIT  = 3;

    typedef enum logic [2:0] {
        FLOW_NONE,
        FLOW_RET,
        FLOW_HALT,
        FLOW_RST,
        FLOW_SET_BCZ,
        FLOW_SET_BCNZ,
        FLOW_CLR_BC
    } flow_op_t;

endpackage

/* isa_pkg.sv */
// isa_pkg: instruction byte encoding of the 8-bit CPU
// field types, execute operation codes and operand kinds for the decoder
package isa_pkg;

    localparam int ADDR_W    = 11;
    localparam int ADDR_HI_W = 3;

    typedef logic [7:0]           inst_t;
    typedef logic [1:0]           reg_idx_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [ADDR_HI_W-1:0] addr_hi_t;    // bits 2:0 of a first byte

    typedef enum logic [2:0] {
        CTRL = 3'd0, ADD = 3'd1, SUB = 3'd2, AND = 3'd3,
        OR   = 3'd4, XOR = 3'd5, LD  = 3'd6, ST  = 3'd7
    } base_op_t;                                 // bits 7:5

    typedef enum logic [1:0] {
        MISC = 2'd0, USR = 2'd1, JMP = 2'd2, CALL = 2'd3
    } ctrl_sub_t;                                // bits 4:3 under CTRL

    typedef enum logic [2:0] {
        NOP = 3'd0, RET = 3'd1, HALT = 3'd2, RST = 3'd3,
        SET_BCZ = 3'd4, SET_BCNZ = 3'd5, CLR_BC = 3'd6
    } misc_op_t;                                 // 7 is illegal

    typedef enum logic [3:0] {
        EXEC_NOP = 4'd0, EXEC_IDLE = 4'd1,
        ALU_ADD  = 4'd2, ALU_SUB = 4'd3, ALU_AND = 4'd4, ALU_OR = 4'd5, ALU_XOR = 4'd6,
        MEM_RD   = 4'd7, MEM_WR  = 4'd8,
        OP_JMP   = 4'd9, OP_CALL = 4'd10, OP_RET = 4'd11
    } exec_op_t;

    typedef enum logic [1:0] {
        OPK_IMM, OPK_MEM, OPK_JMP, OPK_CALL
    } operand_kind_t;                            // meaning of the pending second byte

    // ALU base operation to its execute code
    function automatic exec_op_t alu_exec_op(input base_op_t base);
        case (base)
            ADD:     return ALU_ADD;
            SUB:     return ALU_SUB;
            AND:     return ALU_AND;
            OR:      return ALU_OR;
            XOR:     return ALU_XOR;
            default: return EXEC_NOP;
        endcase
    endfunction

endpackage
